/* include/bringup_defines.svh */
`ifndef BRINGUP_DEFINES_SVH
`define BRINGUP_DEFINES_SVH

// number of chained steps
// one reset output and one done input per step
`define BRINGUP_NSTEP 8

// wishbone word address width
`define BRINGUP_AW 4

// register map in word offsets
`define BRINGUP_REG_CTRL 0
`define BRINGUP_REG_STATUS 1
`define BRINGUP_REG_TIMEOUT 2

// first per-step length word
// step i sits at BRINGUP_REG_STEP0 + i
`define BRINGUP_REG_STEP0 8

`endif

/* rtl/bringup_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bringup_defines.svh"

// wishbone classic slave
// one wait cycle then a single-cycle ack
module bringup_regs
	import wb_pkg::*;
	import seq_pkg::*;
(
	input wire logic clk200,
	input wire logic rst,
	input wire wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input wire step_view_t view,
	input wire logic busy,
	input wire step_idx_t cur_step,
	output logic start_pulse,
	output logic abort_pulse,
	output reg_word_u [`BRINGUP_NSTEP-1:0] step_cfg,
	output logic [31:0] timeout_cycles
);

	localparam logic [`BRINGUP_AW-1:0] ADR_CTRL = `BRINGUP_REG_CTRL;
	localparam logic [`BRINGUP_AW-1:0] ADR_STATUS = `BRINGUP_REG_STATUS;
	localparam logic [`BRINGUP_AW-1:0] ADR_TIMEOUT = `BRINGUP_REG_TIMEOUT;
	localparam logic [`BRINGUP_AW-1:0] ADR_STEP0 = `BRINGUP_REG_STEP0;

	reg_word_u wr_word; // write data, two views
	logic ack_q;
	logic [31:0] rdat_q;
	logic accept; // new cycle seen
	logic wr_en;
	logic ctrl_wr_ack; // control write in its ack cycle
	logic [`BRINGUP_AW-1:0] step_off;
	logic step_hit;
	step_idx_t step_sel;
	logic [31:0] status_word;
	logic [31:0] rd_word;

	assign wr_word = wb_req.dat;
	assign accept = wb_req.cyc && wb_req.stb && !ack_q;
	assign wr_en = accept && wb_req.we;
	assign ctrl_wr_ack = ack_q && wb_req.we && (wb_req.adr == ADR_CTRL);

	// step window decode
	assign step_off = wb_req.adr - ADR_STEP0;
	assign step_hit = (wb_req.adr >= ADR_STEP0) && (step_off < `BRINGUP_NSTEP);
	assign step_sel = step_off[$bits(step_idx_t)-1:0];

	always_comb begin
		status_word = 32'd0;
		status_word[31] = busy;
		status_word[26:24] = cur_step;
		status_word[15:8] = view.error_vec;
		status_word[7:0] = view.done_vec;
	end

	always_comb begin
		if (step_hit) begin
			rd_word = step_cfg[step_sel];
		end else begin
			case (wb_req.adr)
				ADR_STATUS: rd_word = status_word;
				ADR_TIMEOUT: rd_word = timeout_cycles;
				default: rd_word = 32'd0; // ctrl and holes read zero
			endcase
		end
	end

	always_ff @(posedge clk200) begin
		if (rst) begin
			ack_q <= 1'b0;
			start_pulse <= 1'b0;
			abort_pulse <= 1'b0;
			timeout_cycles <= 32'd0; // timeout off
			for (int i = 0; i < `BRINGUP_NSTEP; i++) begin
				step_cfg[i].len.reset_len <= 16'd1;
				step_cfg[i].len.settle_len <= 16'd1;
			end
		end else begin
			ack_q <= accept;
			// pulses land the cycle after ack
			start_pulse <= ctrl_wr_ack && wr_word.cmd.start;
			abort_pulse <= ctrl_wr_ack && wr_word.cmd.abort;
			if (wr_en && (wb_req.adr == ADR_TIMEOUT)) begin
				timeout_cycles <= wb_req.dat;
			end
			if (wr_en && step_hit) begin
				step_cfg[step_sel].len.reset_len <= wr_word.len.reset_len;
				step_cfg[step_sel].len.settle_len <= wr_word.len.settle_len;
			end
		end
	end

	// read data captured with the ack
	always_ff @(posedge clk200) begin
		if (accept) begin
			rdat_q <= rd_word;
		end
	end

	assign wb_rsp.ack = ack_q;
	assign wb_rsp.dat = rdat_q;

endmodule

`default_nettype wire

/* rtl/bringup_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bringup_defines.svh"

// bring-up sequencer top
module bringup_top
	import wb_pkg::*;
	import seq_pkg::*;
(
	input wire logic clk200,
	input wire logic rst,
	input wire wb_req_t wb_req,
	output wb_rsp_t wb_rsp,
	input wire step_vec_t done_in, // asynchronous
	output step_vec_t reset_out
);

	reg_word_u [`BRINGUP_NSTEP-1:0] step_cfg;
	logic [31:0] timeout_cycles;
	logic start_pulse;
	logic abort_pulse;
	step_view_t view;
	step_cmd_t cmd;
	logic busy;
	step_idx_t cur_step;
	logic interval_load;
	logic [31:0] interval_value;
	logic interval_en;
	logic interval_expired;
	logic tmo_load;
	logic tmo_en;
	logic tmo_expired;

	bringup_regs i_regs (
		.clk200(clk200),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.view(view),
		.busy(busy),
		.cur_step(cur_step),
		.start_pulse(start_pulse),
		.abort_pulse(abort_pulse),
		.step_cfg(step_cfg),
		.timeout_cycles(timeout_cycles)
	);

	chain_fsm i_fsm (
		.clk200(clk200),
		.rst(rst),
		.start_pulse(start_pulse),
		.abort_pulse(abort_pulse),
		.step_cfg(step_cfg),
		.timeout_cycles(timeout_cycles),
		.view(view),
		.cmd(cmd),
		.interval_load(interval_load),
		.interval_value(interval_value),
		.interval_en(interval_en),
		.interval_expired(interval_expired),
		.tmo_load(tmo_load),
		.tmo_en(tmo_en),
		.tmo_expired(tmo_expired),
		.busy(busy),
		.cur_step(cur_step)
	);

	step_status i_status (
		.clk200(clk200),
		.rst(rst),
		.done_in(done_in),
		.cmd(cmd),
		.view(view)
	);

	// reset and settle lengths
	step_timer i_interval_timer (
		.clk200(clk200),
		.rst(rst),
		.load(interval_load),
		.load_value(interval_value),
		.enable(interval_en),
		.expired(interval_expired)
	);

	// global done timeout
	step_timer i_timeout_timer (
		.clk200(clk200),
		.rst(rst),
		.load(tmo_load),
		.load_value(timeout_cycles),
		.enable(tmo_en),
		.expired(tmo_expired)
	);

	assign reset_out = view.reset_vec;

endmodule

`default_nettype wire

/* rtl/chain_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bringup_defines.svh"

// walks the chain one step at a time
// all outputs except cur_step are combinational
module chain_fsm
	import wb_pkg::*;
	import seq_pkg::*;
(
	input wire logic clk200,
	input wire logic rst,
	input wire logic start_pulse,
	input wire logic abort_pulse,
	input wire reg_word_u [`BRINGUP_NSTEP-1:0] step_cfg, // per-step lengths
	input wire logic [31:0] timeout_cycles,
	input wire step_view_t view,
	output step_cmd_t cmd,
	output logic interval_load,
	output logic [31:0] interval_value,
	output logic interval_en,
	input wire logic interval_expired,
	output logic tmo_load,
	output logic tmo_en,
	input wire logic tmo_expired,
	output logic busy,
	output step_idx_t cur_step
);

	seq_state_e state;
	seq_state_e state_nxt;
	step_idx_t step_nxt; // step the command addresses
	logic last_step;
	logic tmo_hit;
	logic done_now; // synchronized done of current step

	// a length of n gives n cycles and 0 counts as 1
	function automatic logic [31:0] span(input logic [15:0] len);
		span = (len == 16'd0) ? 32'd0 : {16'd0, len - 16'd1};
	endfunction

	assign last_step = (cur_step == step_idx_t'(`BRINGUP_NSTEP - 1));
	assign tmo_hit = tmo_expired && (timeout_cycles != 32'd0); // zero disables
	assign done_now = view.done_sync[cur_step];

	always_comb begin
		state_nxt = state;
		step_nxt = cur_step;
		cmd = '0;
		interval_load = 1'b0;
		interval_value = 32'd0;
		tmo_load = 1'b0;
		if (abort_pulse) begin
			state_nxt = IDLE; // cmd stays clear so reset_out drops
		end else begin
			case (state)
				IDLE, HALT: begin
					if (start_pulse) begin
						step_nxt = '0;
						cmd.clear_all = 1'b1; // fresh run
						cmd.hold_reset = 1'b1; // first reset cycle
						interval_load = 1'b1;
						interval_value = span(step_cfg[0].len.reset_len);
						state_nxt = RESET;
					end
				end
				RESET: begin
					if (interval_expired) begin
						tmo_load = 1'b1; // timeout runs from reset fall
						state_nxt = WAIT_DONE;
					end else begin
						cmd.hold_reset = 1'b1;
					end
				end
				WAIT_DONE: begin
					if (tmo_hit) begin
						cmd.mark_error = 1'b1;
						state_nxt = HALT;
					end else if (done_now) begin
						interval_load = 1'b1; // first high cycle counts
						interval_value = span(step_cfg[cur_step].len.settle_len);
						state_nxt = SETTLE;
					end
				end
				SETTLE: begin
					if (interval_expired) begin
						cmd.mark_done = 1'b1; // settle_len high cycles seen
						state_nxt = NEXT;
					end else if (tmo_hit) begin
						cmd.mark_error = 1'b1;
						state_nxt = HALT;
					end else if (!done_now) begin
						state_nxt = WAIT_DONE; // glitch restarts the count
					end
				end
				NEXT: begin
					if (last_step) begin
						state_nxt = IDLE; // chain complete
					end else begin
						step_nxt = cur_step + 1'b1;
						cmd.hold_reset = 1'b1;
						interval_load = 1'b1;
						interval_value = span(step_cfg[step_nxt].len.reset_len);
						state_nxt = RESET;
					end
				end
				default: state_nxt = IDLE;
			endcase
		end
		cmd.step = step_nxt;
	end

	always_ff @(posedge clk200) begin
		if (rst) begin
			state <= IDLE;
			cur_step <= '0;
		end else begin
			state <= state_nxt;
			cur_step <= step_nxt; // kept on abort for status
		end
	end

	assign interval_en = (state == RESET) || (state == SETTLE);
	assign tmo_en = (state == WAIT_DONE) || (state == SETTLE);
	assign busy = (state != IDLE) && (state != HALT);

endmodule

`default_nettype wire

/* rtl/seq_pkg.sv */
`default_nettype none

`include "bringup_defines.svh"

package seq_pkg;

	// step index and per-step bit vector
	typedef logic [$clog2(`BRINGUP_NSTEP)-1:0] step_idx_t;
	typedef logic [`BRINGUP_NSTEP-1:0] step_vec_t;

	typedef enum logic [2:0] {
		IDLE, // waiting for start
		RESET, // reset output held
		WAIT_DONE, // waiting for done to rise
		SETTLE, // done must stay high
		NEXT, // advance or finish
		HALT // stopped on timeout
	} seq_state_e;

	// fsm request to the status bank, applied on the next edge
	typedef struct packed {
		step_idx_t step; // addressed step
		logic hold_reset; // reset_out[step] high next cycle
		logic mark_done;
		logic mark_error;
		logic clear_all; // zero done and error
	} step_cmd_t;

	// registered state of all steps
	typedef struct packed {
		step_vec_t done_sync; // done_in after two flops
		step_vec_t reset_vec; // drives reset_out
		step_vec_t done_vec;
		step_vec_t error_vec;
	} step_view_t;

endpackage

`default_nettype wire

/* rtl/step_status.sv */
`timescale 1ns/1ps
`default_nettype none

// per-step flops
// reset outputs leave straight from registers
module step_status
	import seq_pkg::*;
(
	input wire logic clk200,
	input wire logic rst,
	input wire step_vec_t done_in, // asynchronous
	input wire step_cmd_t cmd,
	output step_view_t view
);

	step_vec_t done_meta; // first sync stage
	step_vec_t done_sync;
	step_vec_t reset_vec;
	step_vec_t done_vec;
	step_vec_t error_vec;
	step_vec_t step_sel; // one-hot of cmd.step

	always_comb begin
		step_sel = '0;
		step_sel[cmd.step] = 1'b1;
	end

	// two-flop synchronizer
	always_ff @(posedge clk200) begin
		if (rst) begin
			done_meta <= '0;
			done_sync <= '0;
		end else begin
			done_meta <= done_in;
			done_sync <= done_meta;
		end
	end

	always_ff @(posedge clk200) begin
		if (rst) begin
			reset_vec <= '0;
			done_vec <= '0;
			error_vec <= '0;
		end else begin
			reset_vec <= cmd.hold_reset ? step_sel : '0; // at most one high
			if (cmd.clear_all) begin
				done_vec <= '0;
				error_vec <= '0;
			end else begin
				if (cmd.mark_done) begin
					done_vec <= done_vec | step_sel;
				end
				if (cmd.mark_error) begin
					error_vec <= error_vec | step_sel;
				end
			end
		end
	end

	assign view.done_sync = done_sync;
	assign view.reset_vec = reset_vec;
	assign view.done_vec = done_vec;
	assign view.error_vec = error_vec;

endmodule

`default_nettype wire

/* rtl/step_timer.sv */
`timescale 1ns/1ps
`default_nettype none

// loadable down-counter
// expired stays high while the count sits at zero
module step_timer (
	input wire logic clk200,
	input wire logic rst,
	input wire logic load, // takes load_value
	input wire logic [31:0] load_value,
	input wire logic enable, // count down
	output logic expired
);

	logic [31:0] count;

	always_ff @(posedge clk200) begin
		if (rst) begin
			count <= 32'd0;
		end else if (load) begin
			count <= load_value; // load beats the countdown
		end else if (enable && (count != 32'd0)) begin
			count <= count - 32'd1; // stops at zero
		end
	end

	// zero count means interval over
	assign expired = (count == 32'd0);

endmodule

`default_nettype wire

/* rtl/wb_pkg.sv */
`default_nettype none

`include "bringup_defines.svh"

package wb_pkg;

	// classic cycle request from the master
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		logic [`BRINGUP_AW-1:0] adr; // word address
		logic [31:0] dat; // write data
	} wb_req_t;

	typedef struct packed {
		logic ack; // single cycle
		logic [31:0] dat; // read data, valid with ack
	} wb_rsp_t;

	// step address view
	typedef struct packed {
		logic [15:0] reset_len; // reset cycles
		logic [15:0] settle_len; // done stable cycles
	} len_view_t;

	// control address view
	typedef struct packed {
		logic [29:0] spare;
		logic abort;
		logic start;
	} cmd_view_t;

	typedef union packed {
		len_view_t len;
		cmd_view_t cmd;
	} reg_word_u;

endpackage

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the sequencer testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_bringup -o tb_bringup
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

out=$(./obj_dir/tb_bringup)
status=$?
printf '%s\n' "$out"

if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

# the pass line decides the result
if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
	exit 0
fi

echo "pass message not found"
exit 1

/* sim.f */
+incdir+include
rtl/wb_pkg.sv
rtl/seq_pkg.sv
rtl/step_timer.sv
rtl/step_status.sv
rtl/chain_fsm.sv
rtl/bringup_regs.sv
rtl/bringup_top.sv
tb/tb_bringup.sv

/* tb/bringup_golden.txt */
# op a0 a1 a2, all hex: W adr data, R adr expected, D done_mask, G done_mask delay width
# P step expected_width (0 means no pulse since start), T busy_wait_limit_cycles
# reset state and register map
T 10
R 1 00000000
R 0 00000000
R 2 00000000
R 8 00010001
R f 00010001
R 3 00000000
R 7 00000000
W 2 deadbeef
R 2 deadbeef
W 5 12345678
R 5 00000000
W 2 00000000
# full chain with mixed lengths
W 8 00030001
W 9 00000002
W a 00050000
W b 00010004
W c 00020001
W d 00040003
W e 00070001
R 9 00000002
R e 00070001
D ff
W 0 00000001
T 100
R 1 070000ff
P 0 3
P 1 1
P 2 5
P 3 1
P 4 2
P 5 4
P 6 7
P 7 1
# timeout halt on step 3
W 2 00000020
D f7
W 0 00000001
T 200
R 1 03000807
P 2 5
P 3 1
P 4 0
P 7 0
W 2 00000000
# settle filter on step 2
W a 00050008
D fb
W 0 00000001
G 04 30 05
R 1 82000003
D ff
R 1 82000003
R 1 82000003
T 100
R 1 070000ff
# abort in step 4 reset, then restart
W c 01000001
W 0 00000001
G 00 40 00
W 0 00000002
R 1 0400000f
T 10
W 0 00000001
T 400
R 1 070000ff
P 0 3
P 4 100
P 7 1

/* tb/tb_bringup.sv */
`timescale 1ns/1ps
`default_nettype none

`include "bringup_defines.svh"

// testbench for the bring-up sequencer
// replays tb/bringup_golden.txt against the top level
module tb_bringup
	import wb_pkg::*;
	import seq_pkg::*;
();

	localparam int ACK_LIMIT = 16; // cycles per bus access
	localparam int RUN_LIMIT = 200000; // whole run
	localparam logic [`BRINGUP_AW-1:0] ADR_CTRL = `BRINGUP_REG_CTRL;
	localparam logic [`BRINGUP_AW-1:0] ADR_STATUS = `BRINGUP_REG_STATUS;

	logic clk200;
	logic rst;
	wb_req_t wb_req;
	wb_rsp_t wb_rsp;
	step_vec_t done_in;
	step_vec_t reset_out;

	int mismatch_cnt;
	int fail_cnt;
	int check_cnt;
	int cycle_cnt;
	int width [`BRINGUP_NSTEP]; // last finished pulse or 0 when none since start
	int run_len [`BRINGUP_NSTEP];
	int last_rise; // step of the latest rising reset
	step_vec_t prev_reset;

	bringup_top i_dut (
		.clk200(clk200),
		.rst(rst),
		.wb_req(wb_req),
		.wb_rsp(wb_rsp),
		.done_in(done_in),
		.reset_out(reset_out)
	);

	initial begin
		clk200 = 1'b0;
		forever #2 clk200 = ~clk200; // 4 ns period
	end

	// reset pulse monitor sampled mid-cycle
	always @(negedge clk200) begin
		cycle_cnt++;
		if (!rst) begin
			if ($countones(reset_out) > 1) begin
				fail_cnt++;
				$display("more than one reset output high at once: 0x%02h", reset_out);
			end
			for (int i = 0; i < `BRINGUP_NSTEP; i++) begin
				if (reset_out[i] && !prev_reset[i]) begin
					if (i != 0 && last_rise != i - 1) begin
						fail_cnt++; // chain skipped or reordered
						$display("reset_out[%0d] rose out of order after step %0d", i, last_rise);
					end
					last_rise = i;
					run_len[i] = 0;
				end
				if (reset_out[i]) begin
					run_len[i]++;
				end else if (prev_reset[i]) begin
					width[i] = run_len[i]; // pulse just ended
				end
			end
			prev_reset = reset_out;
		end
	end

	task automatic compare_word(input string name, input reg_word_u got, input reg_word_u exp);
		check_cnt++;
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s got 0x%08h exp 0x%08h", name, got, exp);
		end
	endtask

	task automatic compare_status(input string name, input step_vec_t got, input step_vec_t exp);
		check_cnt++;
		if (got !== exp) begin
			mismatch_cnt++;
			$display("mismatch %s got 0x%02h exp 0x%02h", name, got, exp);
		end
	endtask

	task automatic compare_width(input step_idx_t step, input int got, input int exp);
		check_cnt++;
		if (got != exp) begin
			mismatch_cnt++;
			$display("mismatch reset_out[%0d] width got 0x%0h exp 0x%0h", step, got, exp);
		end
	endtask

	// one classic cycle with the request held until ack
	task automatic bus_cycle(input logic we, input logic [`BRINGUP_AW-1:0] adr,
			input logic [31:0] wdat, output logic [31:0] rdat);
		int n;
		n = 0;
		rdat = 32'd0;
		@(posedge clk200);
		wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
		do begin
			@(negedge clk200);
			n++;
		end while (!wb_rsp.ack && n < ACK_LIMIT);
		if (wb_rsp.ack) begin
			rdat = wb_rsp.dat;
			if (n != 2) begin
				fail_cnt++; // one wait cycle expected
				$display("wishbone ack from address 0x%0h came %0d cycles after the request",
					adr, n);
			end
		end else begin
			fail_cnt++;
			$display("no wishbone ack from address 0x%0h after %0d cycles", adr, n);
		end
		@(posedge clk200);
		wb_req <= '0; // bus idle
		@(negedge clk200);
		if (wb_rsp.ack) begin
			fail_cnt++;
			$display("wishbone ack from address 0x%0h stayed high past one cycle", adr);
		end
	endtask

	// poll busy in the status word and expect all resets low afterwards
	task automatic wait_idle(input int limit);
		int t0;
		logic [31:0] rdat;
		t0 = cycle_cnt;
		bus_cycle(1'b0, ADR_STATUS, 32'd0, rdat);
		while (rdat[31] && (cycle_cnt - t0) < limit) begin
			bus_cycle(1'b0, ADR_STATUS, 32'd0, rdat);
		end
		if (rdat[31]) begin
			fail_cnt++;
			$display("chain still busy after %0d cycles", limit);
		end
		@(negedge clk200);
		compare_status("reset_out when idle", reset_out, '0);
	endtask

	task automatic run_golden();
		int fd;
		int n;
		string line;
		byte op;
		logic [31:0] a0;
		logic [31:0] a1;
		logic [31:0] a2;
		logic [31:0] rdat;
		step_vec_t saved;
		fd = $fopen("tb/bringup_golden.txt", "r");
		if (fd == 0) begin
			fail_cnt++;
			$display("cannot open tb/bringup_golden.txt");
			return;
		end
		while ($fgets(line, fd) != 0) begin
			op = 8'h00;
			a0 = 32'd0;
			a1 = 32'd0;
			a2 = 32'd0;
			n = $sscanf(line, "%c %h %h %h", op, a0, a1, a2);
			case (op)
				"W": begin
					if (a0[`BRINGUP_AW-1:0] == ADR_CTRL && a1[0]) begin
						for (int i = 0; i < `BRINGUP_NSTEP; i++) begin
							width[i] = 0; // fresh run
						end
					end
					bus_cycle(1'b1, a0[`BRINGUP_AW-1:0], a1, rdat);
				end
				"R": begin
					bus_cycle(1'b0, a0[`BRINGUP_AW-1:0], 32'd0, rdat);
					if (a0[`BRINGUP_AW-1:0] == ADR_STATUS) begin
						compare_status("status.done_vec", rdat[7:0], a1[7:0]);
						compare_status("status.error_vec", rdat[15:8], a1[15:8]);
						compare_word("status.busy_step", rdat & 32'hffff0000, a1 & 32'hffff0000);
					end else begin
						compare_word($sformatf("reg[0x%0h]", a0[`BRINGUP_AW-1:0]), rdat, a1);
					end
				end
				"D": begin
					@(posedge clk200);
					done_in <= a0[`BRINGUP_NSTEP-1:0];
				end
				"G": begin
					saved = done_in;
					repeat (a1) @(posedge clk200); // delay before the pulse
					done_in <= saved | a0[`BRINGUP_NSTEP-1:0];
					repeat (a2) @(posedge clk200);
					done_in <= saved;
				end
				"P": compare_width(a0[$bits(step_idx_t)-1:0], width[a0[$bits(step_idx_t)-1:0]],
						int'(a1));
				"T": wait_idle(int'(a0));
				"#", 8'h0a, 8'h0d, 8'h00: ; // comment or blank
				default: begin
					fail_cnt++;
					$display("unknown opcode in golden file, %0d fields read", n);
				end
			endcase
		end
		$fclose(fd);
	endtask

	task automatic print_counts();
		$display("closing: %0d checks, %0d mismatches, %0d other errors",
			check_cnt, mismatch_cnt, fail_cnt);
	endtask

	initial begin
		rst = 1'b1;
		wb_req = '0;
		done_in = '0;
		prev_reset = '0;
		last_rise = 0;
		repeat (10) @(posedge clk200);
		rst <= 1'b0;
		@(posedge clk200);
		run_golden();
		repeat (4) @(posedge clk200);
		print_counts();
		if (mismatch_cnt == 0 && fail_cnt == 0 && check_cnt > 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// hang guard
	initial begin
		repeat (RUN_LIMIT) @(posedge clk200);
		fail_cnt++;
		$display("run did not finish within %0d cycles", RUN_LIMIT);
		print_counts();
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire
